// ==== dv/md5_tb.sv ====
// Self-checking testbench that streams vector messages into the MD5 channel and checks digests
`timescale 1ns/1ps
`include "md5_consts.svh"

module md5_tb;

	localparam int TX_TIMEOUT = 500;
	localparam int RX_TIMEOUT = 2000;

	logic       clk;
	logic       rst;
	logic       wen_i;
	logic       ren_i;
	logic       in_sof_i;
	logic       in_eof_i;
	logic       in_src_rdy_i;
	logic [7:0] in_data_i;
	logic       in_dst_rdy_o;
	logic       out_sof_o;
	logic       out_eof_o;
	logic       out_src_rdy_o;
	logic       out_dst_rdy_i;
	logic [7:0] out_data_o;

	// Blocks of all messages share one queue
	// Digest and block count per message
	logic [511:0] blocks[$];
	logic [127:0] digests[$];
	int           counts[$];

	logic [31:0] lfsr_q;
	logic        stalls_on;
	logic        timed_out;
	logic        hold_off;
	int          checks;
	int          errors;
	int          timeouts;
	int          msgs_sent;
	int          in_bytes;

	md5_channel u_dut (
		.clk           (clk),
		.rst           (rst),
		.wen_i         (wen_i),
		.ren_i         (ren_i),
		.in_sof_i      (in_sof_i),
		.in_eof_i      (in_eof_i),
		.in_src_rdy_i  (in_src_rdy_i),
		.in_data_i     (in_data_i),
		.in_dst_rdy_o  (in_dst_rdy_o),
		.out_sof_o     (out_sof_o),
		.out_eof_o     (out_eof_o),
		.out_src_rdy_o (out_src_rdy_o),
		.out_dst_rdy_i (out_dst_rdy_i),
		.out_data_o    (out_data_o)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------
	// Fibonacci LFSR with taps 32 22 2 1
	// One step for each bit taken
	function automatic logic random_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	// Ready or enable draw
	// High three times in four when stalling
	function automatic logic draw_ready();
		logic a;
		logic b;
		if (!stalls_on)
			return 1'b1;
		a = random_bit();
		b = random_bit();
		return a | b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	// Next line that is neither blank nor a comment
	// Returns zero at end of file
	function automatic int next_line(input int fd, output string line);
		int got;
		got = $fgets(line, fd);
		while (got != 0 && (line.len() < 2 || line.getc(0) == "#"))
			got = $fgets(line, fd);
		return got;
	endfunction

	task automatic read_vectors();
		int           fd;
		int           nb;
		int           n;
		string        line;
		logic [511:0] blk;
		logic [127:0] dig;
		fd = $fopen("dv/md5_vectors.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("Error: could not open the vector file dv/md5_vectors.txt");
			return;
		end
		while (next_line(fd, line) != 0)
		begin
			n = $sscanf(line, "%d", nb);
			for (int b = 0; b < nb; b++)
			begin
				n = next_line(fd, line);
				n = $sscanf(line, "%h", blk);
				blocks.push_back(blk);
			end
			n = next_line(fd, line);
			n = $sscanf(line, "%h", dig);
			digests.push_back(dig);
			counts.push_back(nb);
		end
		$fclose(fd);
	endtask

	//----------------------------------------------------------------------
	// Input side
	//----------------------------------------------------------------------
	// Hold one byte until accepted
	// Offered only while in_dst_rdy_o is high
	task automatic send_byte(input logic [7:0] data, input logic sof, input logic eof);
		int   waited;
		logic sent;
		waited = 0;
		sent = 1'b0;
		while (!sent && !timed_out)
		begin
			in_data_i = data;
			in_sof_i  = sof;
			in_eof_i  = eof;
			if (in_dst_rdy_o)
			begin
				in_src_rdy_i = draw_ready();
				wen_i        = draw_ready();
				sent         = in_src_rdy_i & wen_i;
			end
			else
			begin
				in_src_rdy_i = 1'b0;
				wen_i        = 1'b0;
			end
			if (!sent)
				waited++;
			if (waited > TX_TIMEOUT)
			begin
				timeouts++;
				timed_out = 1'b1;
				$display("Timeout: input side not ready for %0d cycles", TX_TIMEOUT);
			end
			@(posedge clk);
			#1;
		end
		in_src_rdy_i = 1'b0;
		wen_i        = 1'b0;
	endtask

	task automatic send_all();
		int           first;
		logic [511:0] blk;
		first = 0;
		for (int m = 0; m < counts.size() && !timed_out; m++)
		begin
			for (int b = 0; b < counts[m]; b++)
			begin
				blk = blocks[first + b];
				// First byte carries sof and the last byte of the last block carries eof
				for (int i = 0; i < 64; i++)
					send_byte(blk[511 - 8*i -: 8], (b == 0) && (i == 0),
						(b == counts[m] - 1) && (i == 63));
			end
			first += counts[m];
			msgs_sent++;
		end
	endtask

	//----------------------------------------------------------------------
	// Output side
	//----------------------------------------------------------------------
	task automatic receive_digest(input int m, input logic [127:0] exp_dig);
		int i;
		int waited;
		i = 0;
		waited = 0;
		while (i < `MD5_BYTES_PER_WORD && !timed_out)
		begin
			ren_i         = draw_ready();
			out_dst_rdy_i = draw_ready();
			if (out_src_rdy_o && ren_i && out_dst_rdy_i)
			begin
				// Frame only after the message's eof byte went in
				if (i == 0)
				begin
					checks++;
					assert (msgs_sent > m)
					else
					begin
						errors++;
						$display("Error: digest frame %0d started before its last block was sent", m);
					end
				end
				check_value("out_data_o", out_data_o, exp_dig[127 - 8*i -: 8]);
				check_value("out_sof_o", out_sof_o, i == 0);
				check_value("out_eof_o", out_eof_o, i == `MD5_BYTES_PER_WORD - 1);
				i++;
				waited = 0;
			end
			else
				waited++;
			if (waited > RX_TIMEOUT)
			begin
				timeouts++;
				timed_out = 1'b1;
				$display("Timeout: no digest byte for message %0d in %0d cycles", m, RX_TIMEOUT);
			end
			@(posedge clk);
			#1;
		end
		ren_i         = 1'b0;
		out_dst_rdy_i = 1'b0;
		// Frame ends after its sixteenth byte
		if (!timed_out)
			check_value("out_src_rdy_o", out_src_rdy_o, 0);
	endtask

	task automatic receive_all(input int pass);
		for (int m = 0; m < digests.size() && !timed_out; m++)
			receive_digest(pass * digests.size() + m, digests[m]);
	endtask

	// Input closes for the load cycle after every sixteenth accepted byte
	// Bytes are counted mid-cycle and the check falls one cycle later
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (hold_off)
				check_value("in_dst_rdy_o", in_dst_rdy_o, 0);
			hold_off = 1'b0;
			if (in_src_rdy_i && wen_i && in_dst_rdy_o)
			begin
				in_bytes++;
				hold_off = (in_bytes % `MD5_BYTES_PER_WORD == 0);
			end
		end
	end

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------
	initial
	begin
		clk           = 1'b0;
		rst           = 1'b1;
		wen_i         = 1'b0;
		ren_i         = 1'b0;
		in_sof_i      = 1'b0;
		in_eof_i      = 1'b0;
		in_src_rdy_i  = 1'b0;
		in_data_i     = 8'h00;
		out_dst_rdy_i = 1'b0;
		lfsr_q        = 32'h0deac3db;
		stalls_on     = 1'b0;
		timed_out     = 1'b0;
		hold_off      = 1'b0;
		checks        = 0;
		errors        = 0;
		timeouts      = 0;
		msgs_sent     = 0;
		in_bytes      = 0;
		read_vectors();
		check_value("message count", counts.size(), 3);

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle after reset with nothing offered yet
		for (int c = 0; c < 10; c++)
		begin
			check_value("out_src_rdy_o", out_src_rdy_o, 0);
			check_value("in_dst_rdy_o", in_dst_rdy_o, 1);
			@(posedge clk);
			#1;
		end

		// Pass 0 streams freely and pass 1 stalls both sides at random
		for (int pass = 0; pass < 2 && !timed_out; pass++)
		begin
			stalls_on = (pass == 1);
			fork
				send_all();
				receive_all(pass);
			join
		end

		// Input side open again once the last frame is read
		check_value("in_dst_rdy_o", in_dst_rdy_o, 1);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== dv/md5_vectors.txt ====
# Per message: block count, then each padded 64-byte block as 128 hex digits,
# then the expected 16-byte digest as 32 hex digits, all in stream byte order
1
80000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
d41d8cd98f00b204e9800998ecf8427e
1
61626380000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000001800000000000000
900150983cd24fb0d6963f7d28e17f72
2
6162636462636465636465666465666765666768666768696768696a68696a6b696a6b6c6a6b6c6d6b6c6d6e6c6d6e6f6d6e6f706e6f70718000000000000000
00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000c001000000000000
8215ef0796a20bcaaae116d3876c664a

// ==== hdl/md5_channel.sv ====
// MD5 hashing channel top level: framed byte stream in, 16-byte digest frame out
`timescale 1ns/1ps
`include "md5_consts.svh"

module md5_channel
	import md5_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       wen_i,
	input  logic       ren_i,
	input  logic       in_sof_i,
	input  logic       in_eof_i,
	input  logic       in_src_rdy_i,
	input  logic [7:0] in_data_i,
	output logic       in_dst_rdy_o,
	output logic       out_sof_o,
	output logic       out_eof_o,
	output logic       out_src_rdy_o,
	input  logic       out_dst_rdy_i,
	output logic [7:0] out_data_o
);

	// Write FSM encoding
	localparam logic [1:0] W_FILL  = 2'd0;
	localparam logic [1:0] W_LOAD  = 2'd1;
	localparam logic [1:0] W_BUSY  = 2'd2;
	localparam logic [1:0] W_DRAIN = 2'd3;
	// Read FSM encoding
	localparam logic R_IDLE = 1'b0;
	localparam logic R_SEND = 1'b1;

	logic [1:0] w_state;
	logic       r_state;
	logic [3:0] byte_cnt;
	logic [1:0] word_cnt;
	logic [3:0] rd_cnt;
	logic       eof_q;
	logic       newtext_q;
	logic       in_acc;
	logic       out_xfer;
	logic       rd_start;
	logic       rd_last;
	logic       core_ready;
	md5_word_t  in_word;
	md5_word_t  load_word;
	md5_word_t  digest;
	md5_word_t  out_word;

	// MD5 words are little endian, the stream is big endian per lane
	function automatic logic [31:0] bswap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Handshakes
	assign in_acc   = wen_i & in_src_rdy_i & in_dst_rdy_o;
	assign out_xfer = out_src_rdy_o & ren_i & out_dst_rdy_i;
	assign rd_start = (r_state == R_IDLE) & core_ready & eof_q;
	assign rd_last  = out_xfer & (rd_cnt == 4'd0);

	//----------------------------------------------------------------------
	// Write FSM, byte and word counters
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_state   <= W_FILL;
			byte_cnt  <= 4'd0;
			word_cnt  <= 2'd0;
			eof_q     <= 1'b0;
			newtext_q <= 1'b0;
		end
		else
		begin
			case (w_state)
				W_FILL:
					if (in_acc)
					begin
						byte_cnt <= byte_cnt + 4'd1;
						if (byte_cnt == 4'(`MD5_BYTES_PER_WORD - 1))
							w_state <= W_LOAD;
					end
				W_LOAD:
				begin
					// Core load pulse, newtext goes out with it
					word_cnt  <= word_cnt + 2'd1;
					newtext_q <= 1'b0;
					if (word_cnt == 2'(`MD5_WORDS_PER_BLOCK - 1))
						w_state <= W_BUSY;
					else
						w_state <= W_FILL;
				end
				W_BUSY:
					if (core_ready)
					begin
						eof_q   <= 1'b0;
						w_state <= eof_q ? W_DRAIN : W_FILL;
					end
				default:
					// Hold input off until the digest frame is gone
					if (rd_last)
						w_state <= W_FILL;
			endcase
			if (in_acc & in_sof_i)
				newtext_q <= 1'b1;
			if (in_acc & in_eof_i)
				eof_q <= 1'b1;
		end
	end

	// Input shift register, newest byte at the bottom
	always_ff @(posedge clk)
	begin
		if (in_acc)
			in_word.bytes <= {in_word.bytes[`MD5_BYTES_PER_WORD-2:0], in_data_i};
	end

	always_comb
	begin
		for (int k = 0; k < `MD5_BYTES_PER_WORD/4; k++)
			load_word.lanes[k] = bswap(in_word.lanes[k]);
	end

	//----------------------------------------------------------------------
	// Core
	//----------------------------------------------------------------------
	md5_core u_core (
		.clk       (clk),
		.rst       (rst),
		.newtext_i ((w_state == W_LOAD) & newtext_q),
		.load_i    (w_state == W_LOAD),
		.data_i    (load_word),
		.ready_o   (core_ready),
		.digest_o  (digest)
	);

	//----------------------------------------------------------------------
	// Read FSM and digest shifter
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			r_state <= R_IDLE;
			rd_cnt  <= 4'd0;
		end
		else if (rd_start)
		begin
			r_state <= R_SEND;
			rd_cnt  <= 4'(`MD5_BYTES_PER_WORD - 1);
		end
		else if (out_xfer)
		begin
			rd_cnt <= rd_cnt - 4'd1;
			if (rd_cnt == 4'd0)
				r_state <= R_IDLE;
		end
	end

	// Low byte of A lands on top, so it leaves first
	always_ff @(posedge clk)
	begin
		if (rd_start)
			for (int k = 0; k < `MD5_BYTES_PER_WORD/4; k++)
				out_word.lanes[k] <= bswap(digest.lanes[k]);
		else if (out_xfer)
			out_word.bytes <= {out_word.bytes[`MD5_BYTES_PER_WORD-2:0], 8'h00};
	end

	// Frame markers from the down-counter
	assign out_src_rdy_o = (r_state == R_SEND);
	assign out_sof_o     = out_src_rdy_o & (rd_cnt == 4'(`MD5_BYTES_PER_WORD - 1));
	assign out_eof_o     = out_src_rdy_o & (rd_cnt == 4'd0);
	assign out_data_o    = out_word.bytes[`MD5_BYTES_PER_WORD-1];
	assign in_dst_rdy_o  = (w_state == W_FILL);

endmodule

// ==== hdl/md5_consts.svh ====
// MD5 sizes and initial chaining words, included by the package and the RTL modules
`ifndef MD5_CONSTS_SVH
`define MD5_CONSTS_SVH

// Compression steps per 512-bit block
`define MD5_STEPS 64

// Bytes per 128-bit channel word, also the digest length in bytes
`define MD5_BYTES_PER_WORD 16

// 128-bit loads per 512-bit block
`define MD5_WORDS_PER_BLOCK 4

//----------------------------------------------------------------------
// Standard initial chaining value, A through D
//----------------------------------------------------------------------
`define MD5_IV_A 32'h67452301
`define MD5_IV_B 32'hefcdab89
`define MD5_IV_C 32'h98badcfe
`define MD5_IV_D 32'h10325476

`endif

// ==== hdl/md5_core.sv ====
// Iterative MD5 core: takes four 128-bit loads per block, runs 64 steps, keeps the digest
`timescale 1ns/1ps
`include "md5_consts.svh"

module md5_core
	import md5_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         newtext_i,
	input  logic         load_i,
	input  md5_word_t    data_i,
	output logic         ready_o,
	output logic [127:0] digest_o
);

	md5_block_t  block_q;
	logic [1:0]  load_cnt;
	logic        last_load;
	logic        fresh_q;
	logic        busy_q;
	logic        add_q;
	logic [5:0]  step_q;
	logic [31:0] a_q;
	logic [31:0] b_q;
	logic [31:0] c_q;
	logic [31:0] d_q;
	logic [31:0] ha_q;
	logic [31:0] hb_q;
	logic [31:0] hc_q;
	logic [31:0] hd_q;
	logic [31:0] base_a;
	logic [31:0] base_b;
	logic [31:0] base_c;
	logic [31:0] base_d;
	logic [31:0] b_next;

	// Fourth load of a block starts compression
	assign last_load = load_i & (load_cnt == 2'(`MD5_WORDS_PER_BLOCK - 1));

	// Chaining base, IV for the first block of a new message
	// The old digest stays visible until this block is added in
	assign base_a = fresh_q ? `MD5_IV_A : ha_q;
	assign base_b = fresh_q ? `MD5_IV_B : hb_q;
	assign base_c = fresh_q ? `MD5_IV_C : hc_q;
	assign base_d = fresh_q ? `MD5_IV_D : hd_q;

	//----------------------------------------------------------------------
	// Step logic
	//----------------------------------------------------------------------
	md5_step u_step (
		.step_i   (step_q),
		.a_i      (a_q),
		.b_i      (b_q),
		.c_i      (c_q),
		.d_i      (d_q),
		.block_i  (block_q),
		.b_next_o (b_next)
	);

	//----------------------------------------------------------------------
	// Control and chaining registers
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			load_cnt <= 2'd0;
			fresh_q  <= 1'b0;
			busy_q   <= 1'b0;
			add_q    <= 1'b0;
			step_q   <= 6'd0;
			ready_o  <= 1'b0;
			ha_q     <= `MD5_IV_A;
			hb_q     <= `MD5_IV_B;
			hc_q     <= `MD5_IV_C;
			hd_q     <= `MD5_IV_D;
		end
		else
		begin
			ready_o <= 1'b0;
			if (newtext_i)
				fresh_q <= 1'b1;
			// Two-bit counter wraps after the fourth load
			if (load_i)
				load_cnt <= load_cnt + 2'd1;
			if (last_load)
			begin
				busy_q <= 1'b1;
				step_q <= 6'd0;
			end
			else if (busy_q)
			begin
				step_q <= step_q + 6'd1;
				if (step_q == 6'(`MD5_STEPS - 1))
				begin
					busy_q <= 1'b0;
					add_q  <= 1'b1;
				end
			end
			// Final add, one cycle after step 63
			if (add_q)
			begin
				add_q   <= 1'b0;
				fresh_q <= 1'b0;
				ready_o <= 1'b1;
				ha_q    <= base_a + a_q;
				hb_q    <= base_b + b_q;
				hc_q    <= base_c + c_q;
				hd_q    <= base_d + d_q;
			end
		end
	end

	//----------------------------------------------------------------------
	// Block store and working registers
	//----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		// Lane 3 carries the earliest message word of the load
		if (load_i)
			for (int k = 0; k < `MD5_BYTES_PER_WORD/4; k++)
				block_q[{load_cnt, 2'(k)}] <= data_i.lanes[3 - k];
		if (last_load)
		begin
			a_q <= base_a;
			b_q <= base_b;
			c_q <= base_c;
			d_q <= base_d;
		end
		else if (busy_q)
		begin
			// A <- D, B <- new, C <- B, D <- C
			a_q <= d_q;
			b_q <= b_next;
			c_q <= b_q;
			d_q <= c_q;
		end
	end

	assign digest_o = {ha_q, hb_q, hc_q, hd_q};

endmodule

// ==== hdl/md5_pkg.sv ====
// MD5 shared types and step constant lookups, imported by the channel, core and step logic
`include "md5_consts.svh"

package md5_pkg;

	// Channel word, seen either as bytes or as 32-bit lanes
	// Byte 15 is the oldest byte shifted in, lane 3 holds bytes 15..12
	typedef union packed {
		logic [`MD5_BYTES_PER_WORD-1:0][7:0]   bytes;
		logic [`MD5_BYTES_PER_WORD/4-1:0][31:0] lanes;
	} md5_word_t;

	// One 512-bit block, index 0 is message word M[0]
	typedef logic [`MD5_WORDS_PER_BLOCK*4-1:0][31:0] md5_block_t;

	//----------------------------------------------------------------------
	// Additive constants, floor(abs(sin(i + 1)) * 2^32)
	//----------------------------------------------------------------------
	localparam logic [31:0] K_TABLE [`MD5_STEPS] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	//----------------------------------------------------------------------
	// Rotate amounts, four per round, repeating every four steps
	//----------------------------------------------------------------------
	localparam logic [4:0] SHIFT_TABLE [16] = '{
		5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9,  5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21
	};

	// Constant for a given step
	function automatic logic [31:0] md5_k(input logic [5:0] step);
		return K_TABLE[step];
	endfunction

	// Rotate amount from round number and position within the group of four
	function automatic logic [4:0] md5_shift(input logic [5:0] step);
		logic [3:0] sel;
		sel = {step[5:4], step[1:0]};
		return SHIFT_TABLE[sel];
	endfunction

endpackage

// ==== hdl/md5_step.sv ====
// One MD5 compression step, combinational, evaluated once per cycle by the core
`timescale 1ns/1ps

module md5_step
	import md5_pkg::*;
(
	input  logic [5:0]  step_i,
	input  logic [31:0] a_i,
	input  logic [31:0] b_i,
	input  logic [31:0] c_i,
	input  logic [31:0] d_i,
	input  md5_block_t  block_i,
	output logic [31:0] b_next_o
);

	logic [1:0]  quarter;
	logic [3:0]  idx;
	logic [31:0] func;
	logic [31:0] sum;
	logic [4:0]  shift;
	logic [31:0] rotated;

	// Round number from the top two step bits
	assign quarter = step_i[5:4];

	// Round function and message word order
	// Word index arithmetic wraps at 16 on its own
	always_comb
	begin
		case (quarter)
			2'd0:
			begin
				func = (b_i & c_i) | (~b_i & d_i);
				idx  = step_i[3:0];
			end
			2'd1:
			begin
				func = (b_i & d_i) | (c_i & ~d_i);
				idx  = step_i[3:0] * 4'd5 + 4'd1;
			end
			2'd2:
			begin
				func = b_i ^ c_i ^ d_i;
				idx  = step_i[3:0] * 4'd3 + 4'd5;
			end
			default:
			begin
				func = c_i ^ (b_i | ~d_i);
				idx  = step_i[3:0] * 4'd7;
			end
		endcase
	end

	// Four-way add, then rotate left
	assign sum     = a_i + func + md5_k(step_i) + block_i[idx];
	assign shift   = md5_shift(step_i);
	assign rotated = (sum << shift) | (sum >> (6'd32 - {1'b0, shift}));

	// New B, the other three words just rotate in the core
	assign b_next_o = b_i + rotated;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the MD5 channel testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module md5_tb -o md5_sim \
	&& ./obj_dir/md5_sim | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// ==== verilog.f ====
+incdir+hdl
hdl/md5_pkg.sv
hdl/md5_step.sv
hdl/md5_core.sv
hdl/md5_channel.sv
dv/md5_tb.sv
